// File: hdl/soc_bus_pkg.sv
// ####################
// Peripheral bus package
// APB request and response structs, bus widths
// and the DMA engine state encoding
// ####################
package soc_bus_pkg;

	// Bus widths
	localparam int DATA_W = 32;
	localparam int ADDR_W = 16;
	localparam int STRB_W = DATA_W / 8;

	// Requester side of an APB transfer
	typedef struct packed {
		logic              psel;
		logic              penable;
		logic              pwrite;
		logic [ADDR_W-1:0] paddr;
		logic [DATA_W-1:0] pwdata;
		logic [STRB_W-1:0] pstrb;
	} apb_req_t;

	// Completer side, no error signalling on this bus
	typedef struct packed {
		logic              pready;
		logic [DATA_W-1:0] prdata;
	} apb_rsp_t;

	// DMA copy sequence, one read then one write per word
	typedef enum logic [1:0] {
		IDLE,
		READ,
		WRITE
	} dma_state_t;

endpackage

// File: hdl/soc_map_pkg.sv
// ####################
// Peripheral map package
// Slot numbering, address decode, device table
// contents and interrupt source indices
// ####################
package soc_map_pkg;

	// Slot values match bits 15..12 of the byte address
	typedef enum logic [2:0] {
		SLOT_RAM     = 3'd0,
		SLOT_DEVTBL  = 3'd1,
		SLOT_GPIO    = 3'd2,
		SLOT_INTCTRL = 3'd3,
		SLOT_DMA     = 3'd4,
		SLOT_NONE    = 3'd5
	} slot_t;

	localparam int SLOT_COUNT      = 5;
	localparam int SLOT_BASE_SHIFT = 12;

	// Device table contents, indexed by slot
	localparam logic [31:0] MAP_SZ [SLOT_COUNT] = '{
		32'h1000, 32'h1000, 32'h1000, 32'h1000, 32'h1000
	};
	localparam logic [31:0] DEV_ID [SLOT_COUNT] = '{
		32'd1, 32'd7, 32'd6, 32'd3, 32'd2
	};
	localparam logic USE_INTR [SLOT_COUNT] = '{
		1'b0, 1'b0, 1'b1, 1'b0, 1'b1
	};

	// Interrupt sources
	localparam int INT_SRC_GPIO  = 0;
	localparam int INT_SRC_DMA   = 1;
	localparam int INT_SRC_COUNT = 2;

	localparam int GPIO_W    = 16;
	localparam int RAM_WORDS = 1024;

endpackage

// File: hdl/scratch_ram.sv
// ####################
// Scratch RAM
// Word RAM with byte strobes, read data is
// captured in setup for the access cycle
// ####################
module scratch_ram (
	input  logic                  clk_2x_w,
	input  soc_bus_pkg::apb_req_t req_i,
	input  logic                  sel_i,
	output soc_bus_pkg::apb_rsp_t rsp_o
);
	import soc_bus_pkg::*;
	import soc_map_pkg::*;

	logic [DATA_W-1:0]            mem_r [RAM_WORDS];
	logic [DATA_W-1:0]            rdata_r;
	logic [$clog2(RAM_WORDS)-1:0] idx_w;

	assign idx_w = req_i.paddr[$clog2(RAM_WORDS)+1:2];

	always_ff @(posedge clk_2x_w) begin
		if (sel_i && !req_i.penable) begin
			rdata_r <= mem_r[idx_w];
		end
		if (sel_i && req_i.penable && req_i.pwrite) begin
			for (int b = 0; b < STRB_W; b++) begin
				if (req_i.pstrb[b]) begin
					mem_r[idx_w][b*8 +: 8] <= req_i.pwdata[b*8 +: 8];
				end
			end
		end
	end

	// No wait states
	assign rsp_o.pready = sel_i && req_i.penable;
	assign rsp_o.prdata = rdata_r;

endmodule

// File: hdl/dev_table.sv
// ####################
// Device table
// Read-only list of slot id, map size and
// interrupt use, four words per entry
// ####################
module dev_table (
	input  logic                  clk_2x_w,
	input  soc_bus_pkg::apb_req_t req_i,
	input  logic                  sel_i,
	output soc_bus_pkg::apb_rsp_t rsp_o
);
	import soc_bus_pkg::*;
	import soc_map_pkg::*;

	logic [SLOT_BASE_SHIFT-5:0] entry_w;
	logic [DATA_W-1:0]          word_w;
	logic [DATA_W-1:0]          rdata_r;

	assign entry_w = req_i.paddr[SLOT_BASE_SHIFT-1:4];

	// Entries past the last slot and the fourth word read zero
	always_comb begin
		word_w = '0;
		for (int i = 0; i < SLOT_COUNT; i++) begin
			if (int'(entry_w) == i) begin
				case (req_i.paddr[3:2])
					2'd0:    word_w = DEV_ID[i];
					2'd1:    word_w = MAP_SZ[i];
					2'd2:    word_w = {{(DATA_W-1){1'b0}}, USE_INTR[i]};
					default: word_w = '0;
				endcase
			end
		end
	end

	always_ff @(posedge clk_2x_w) begin
		if (sel_i && !req_i.penable) begin
			rdata_r <= word_w;
		end
	end

	assign rsp_o.pready = sel_i && req_i.penable;
	assign rsp_o.prdata = rdata_r;

endmodule

// File: hdl/gpio_port.sv
// ####################
// GPIO port
// Two-flop input synchronizer, output register
// and an interrupt on any input change
// ####################
module gpio_port (
	input  logic                           clk_2x_w,
	input  logic                           rst_p,
	input  soc_bus_pkg::apb_req_t          req_i,
	input  logic                           sel_i,
	output soc_bus_pkg::apb_rsp_t          rsp_o,
	input  logic [soc_map_pkg::GPIO_W-1:0] gpio_i,
	output logic [soc_map_pkg::GPIO_W-1:0] gpio_o,
	output logic                           intrqst_o,
	input  logic                           intrdy_i
);
	import soc_bus_pkg::*;
	import soc_map_pkg::*;

	logic [GPIO_W-1:0] meta_r;
	logic [GPIO_W-1:0] sync_r;
	logic [GPIO_W-1:0] last_r;
	logic [GPIO_W-1:0] out_r;
	logic              intrqst_r;
	logic              change_w;

	assign change_w = |(sync_r ^ last_r);

	always_ff @(posedge clk_2x_w) begin
		if (rst_p) begin
			meta_r    <= '0;
			sync_r    <= '0;
			last_r    <= '0;
			out_r     <= '0;
			intrqst_r <= 1'b0;
		end else begin
			meta_r <= gpio_i;
			sync_r <= meta_r;
			last_r <= sync_r;
			// A new change keeps the request even during an acknowledge
			if (change_w) begin
				intrqst_r <= 1'b1;
			end else if (intrdy_i) begin
				intrqst_r <= 1'b0;
			end
			if (sel_i && req_i.penable && req_i.pwrite && req_i.paddr[3:2] == 2'd1) begin
				for (int b = 0; b < GPIO_W / 8; b++) begin
					if (req_i.pstrb[b]) begin
						out_r[b*8 +: 8] <= req_i.pwdata[b*8 +: 8];
					end
				end
			end
		end
	end

	assign rsp_o.pready = sel_i && req_i.penable;
	assign rsp_o.prdata = (req_i.paddr[3:2] == 2'd1) ? {{(DATA_W-GPIO_W){1'b0}}, out_r} :
		{{(DATA_W-GPIO_W){1'b0}}, sync_r};

	assign gpio_o    = out_r;
	assign intrqst_o = intrqst_r;

endmodule

// File: hdl/int_ctrl.sv
// ####################
// Interrupt controller
// Latches source requests into pending, masks
// them with enable and drives the host irq
// ####################
module int_ctrl (
	input  logic                                  clk_2x_w,
	input  logic                                  rst_p,
	input  soc_bus_pkg::apb_req_t                 req_i,
	input  logic                                  sel_i,
	output soc_bus_pkg::apb_rsp_t                 rsp_o,
	input  logic [soc_map_pkg::INT_SRC_COUNT-1:0] intrqst_i,
	output logic [soc_map_pkg::INT_SRC_COUNT-1:0] intrdy_o,
	output logic                                  irq_o
);
	import soc_bus_pkg::*;
	import soc_map_pkg::*;

	logic [INT_SRC_COUNT-1:0] pending_r;
	logic [INT_SRC_COUNT-1:0] enable_r;
	logic [INT_SRC_COUNT-1:0] ack_w;
	logic                     wr_w;

	assign wr_w = sel_i && req_i.penable && req_i.pwrite;

	// Acknowledge lasts for the access cycle of the write only,
	// so the source drops its request as pending clears
	assign ack_w = (wr_w && req_i.paddr[3:2] == 2'd0) ? req_i.pwdata[INT_SRC_COUNT-1:0] : '0;

	always_ff @(posedge clk_2x_w) begin
		if (rst_p) begin
			pending_r <= '0;
			enable_r  <= '0;
		end else begin
			pending_r <= (pending_r | intrqst_i) & ~ack_w;
			if (wr_w && req_i.paddr[3:2] == 2'd1) begin
				enable_r <= req_i.pwdata[INT_SRC_COUNT-1:0];
			end
		end
	end

	assign rsp_o.pready = sel_i && req_i.penable;
	assign rsp_o.prdata = (req_i.paddr[3:2] == 2'd1) ?
		{{(DATA_W-INT_SRC_COUNT){1'b0}}, enable_r} :
		{{(DATA_W-INT_SRC_COUNT){1'b0}}, pending_r};

	assign intrdy_o = ack_w & pending_r;
	assign irq_o    = |(pending_r & enable_r);

endmodule

// File: hdl/dma_engine.sv
// ####################
// One-channel DMA engine
// Register slave for src, dst, count and status,
// APB requester that copies count words
// ####################
module dma_engine (
	input  logic                  clk_2x_w,
	input  logic                  rst_p,
	input  soc_bus_pkg::apb_req_t req_i,
	input  logic                  sel_i,
	output soc_bus_pkg::apb_rsp_t rsp_o,
	output soc_bus_pkg::apb_req_t mst_req_o,
	input  soc_bus_pkg::apb_rsp_t mst_rsp_i,
	output logic                  intrqst_o,
	input  logic                  intrdy_i
);
	import soc_bus_pkg::*;

	dma_state_t        state_r;
	logic              penable_r;
	logic              intrqst_r;
	logic [ADDR_W-1:0] src_r;
	logic [ADDR_W-1:0] dst_r;
	logic [ADDR_W-1:0] count_r;
	logic [DATA_W-1:0] data_r;
	logic              reg_wr_w;
	logic              start_w;
	logic              xfer_done_w;
	logic              busy_w;
	logic [DATA_W-1:0] rd_w;

	assign busy_w      = (state_r != IDLE);
	assign reg_wr_w    = sel_i && req_i.penable && req_i.pwrite && !busy_w;
	assign start_w     = reg_wr_w && req_i.paddr[3:2] == 2'd2 && req_i.pwdata[ADDR_W-1:0] != '0;
	assign xfer_done_w = penable_r && mst_rsp_i.pready;

	always_comb begin
		case (req_i.paddr[3:2])
			2'd0:    rd_w = {{(DATA_W-ADDR_W){1'b0}}, src_r};
			2'd1:    rd_w = {{(DATA_W-ADDR_W){1'b0}}, dst_r};
			2'd2:    rd_w = {{(DATA_W-ADDR_W){1'b0}}, count_r};
			default: rd_w = {{(DATA_W-1){1'b0}}, busy_w};
		endcase
	end

	assign rsp_o.pready = sel_i && req_i.penable;
	assign rsp_o.prdata = rd_w;

	always_comb begin
		mst_req_o         = '0;
		mst_req_o.psel    = busy_w;
		mst_req_o.penable = penable_r;
		mst_req_o.pwrite  = (state_r == WRITE);
		mst_req_o.paddr   = (state_r == WRITE) ? dst_r : src_r;
		mst_req_o.pwdata  = data_r;
		mst_req_o.pstrb   = '1;
	end

	always_ff @(posedge clk_2x_w) begin
		if (rst_p) begin
			state_r   <= IDLE;
			penable_r <= 1'b0;
			count_r   <= '0;
			intrqst_r <= 1'b0;
		end else begin
			// Setup for one cycle, then access until pready
			penable_r <= busy_w && !xfer_done_w;
			if (intrdy_i) begin
				intrqst_r <= 1'b0;
			end
			if (reg_wr_w && req_i.paddr[3:2] == 2'd2) begin
				count_r <= req_i.pwdata[ADDR_W-1:0];
			end
			case (state_r)
				IDLE: begin
					if (start_w) begin
						state_r <= READ;
					end
				end
				READ: begin
					if (xfer_done_w) begin
						state_r <= WRITE;
					end
				end
				default: begin
					if (xfer_done_w) begin
						count_r <= count_r - 1'b1;
						if (count_r == ADDR_W'(1)) begin
							state_r   <= IDLE;
							intrqst_r <= 1'b1;
						end else begin
							state_r <= READ;
						end
					end
				end
			endcase
		end
	end

	// Addresses and the word in flight
	always_ff @(posedge clk_2x_w) begin
		if (reg_wr_w && req_i.paddr[3:2] == 2'd0) begin
			src_r <= req_i.pwdata[ADDR_W-1:0];
		end
		if (reg_wr_w && req_i.paddr[3:2] == 2'd1) begin
			dst_r <= req_i.pwdata[ADDR_W-1:0];
		end
		if (state_r == READ && xfer_done_w) begin
			data_r <= mst_rsp_i.prdata;
		end
		if (state_r == WRITE && xfer_done_w) begin
			src_r <= src_r + ADDR_W'(STRB_W);
			dst_r <= dst_r + ADDR_W'(STRB_W);
		end
	end

	assign intrqst_o = intrqst_r;

endmodule

// File: hdl/bus_fabric.sv
// ####################
// APB bus fabric
// Fixed-priority arbiter between host and DMA,
// setup/access sequencing toward the slaves,
// slot decoder and default slave
// ####################
module bus_fabric (
	input  logic                                          clk_2x_w,
	input  logic                                          rst_p,
	input  soc_bus_pkg::apb_req_t                         host_req_i,
	output soc_bus_pkg::apb_rsp_t                         host_rsp_o,
	input  soc_bus_pkg::apb_req_t                         dma_req_i,
	output soc_bus_pkg::apb_rsp_t                         dma_rsp_o,
	output soc_bus_pkg::apb_req_t                         slv_req_o,
	output logic [soc_map_pkg::SLOT_COUNT-1:0]            slv_sel_o,
	input  soc_bus_pkg::apb_rsp_t [soc_map_pkg::SLOT_COUNT-1:0] slv_rsp_i
);
	import soc_bus_pkg::*;
	import soc_map_pkg::*;

	// High while the granted transfer is in its access phase
	logic                              grant_r;
	logic                              owner_dma_r;
	logic                              owner_dma_w;
	logic [ADDR_W-SLOT_BASE_SHIFT-1:0] page_w;
	slot_t                             slot_w;
	apb_rsp_t                          rsp_w;

	// Host wins a tie when the bus is free
	assign owner_dma_w = grant_r ? owner_dma_r : !host_req_i.psel;

	// The fabric runs its own setup and access phases, since a
	// waiting requester may already hold penable high
	always_comb begin
		slv_req_o         = owner_dma_w ? dma_req_i : host_req_i;
		slv_req_o.psel    = grant_r || host_req_i.psel || dma_req_i.psel;
		slv_req_o.penable = grant_r;
	end

	assign page_w = slv_req_o.paddr[ADDR_W-1:SLOT_BASE_SHIFT];

	always_comb begin
		case (page_w)
			4'h0:    slot_w = SLOT_RAM;
			4'h1:    slot_w = SLOT_DEVTBL;
			4'h2:    slot_w = SLOT_GPIO;
			4'h3:    slot_w = SLOT_INTCTRL;
			4'h4:    slot_w = SLOT_DMA;
			default: slot_w = SLOT_NONE;
		endcase
	end

	always_comb begin
		slv_sel_o = '0;
		if (slv_req_o.psel && slot_w != SLOT_NONE) begin
			slv_sel_o[slot_w] = 1'b1;
		end
	end

	// Unmapped pages read zero and complete in the access cycle
	always_comb begin
		rsp_w.pready = grant_r;
		rsp_w.prdata = '0;
		if (slot_w != SLOT_NONE) begin
			rsp_w = slv_rsp_i[slot_w];
		end
	end

	// Only the owner sees pready, the other requester is held off
	always_comb begin
		host_rsp_o        = rsp_w;
		dma_rsp_o         = rsp_w;
		host_rsp_o.pready = rsp_w.pready && grant_r && !owner_dma_r;
		dma_rsp_o.pready  = rsp_w.pready && grant_r && owner_dma_r;
	end

	always_ff @(posedge clk_2x_w) begin
		if (rst_p) begin
			grant_r     <= 1'b0;
			owner_dma_r <= 1'b0;
		end else if (!grant_r) begin
			grant_r     <= slv_req_o.psel;
			owner_dma_r <= owner_dma_w;
		end else if (rsp_w.pready) begin
			grant_r <= 1'b0;
		end
	end

endmodule

// File: hdl/soc_top.sv
// ####################
// Peripheral system top level
// Host port and DMA share one APB through the
// fabric, which serves RAM, device table, GPIO,
// interrupt controller and DMA registers
// ####################
module soc_top (
	input  logic                             clk_2x_w,
	input  logic                             rst_p,
	input  soc_bus_pkg::apb_req_t            host_req_i,
	output soc_bus_pkg::apb_rsp_t            host_rsp_o,
	input  logic [soc_map_pkg::GPIO_W-1:0]   gpio_i,
	output logic [soc_map_pkg::GPIO_W-1:0]   gpio_o,
	output logic                             irq_o
);
	import soc_bus_pkg::*;
	import soc_map_pkg::*;

	apb_req_t                    dma_mst_req_w;
	apb_rsp_t                    dma_mst_rsp_w;
	apb_req_t                    slv_req_w;
	logic [SLOT_COUNT-1:0]       slv_sel_w;
	apb_rsp_t [SLOT_COUNT-1:0]   slv_rsp_w;
	logic [INT_SRC_COUNT-1:0]    intrqst_w;
	logic [INT_SRC_COUNT-1:0]    intrdy_w;

	bus_fabric u_bus_fabric (
		.clk_2x_w   (clk_2x_w),
		.rst_p      (rst_p),
		.host_req_i (host_req_i),
		.host_rsp_o (host_rsp_o),
		.dma_req_i  (dma_mst_req_w),
		.dma_rsp_o  (dma_mst_rsp_w),
		.slv_req_o  (slv_req_w),
		.slv_sel_o  (slv_sel_w),
		.slv_rsp_i  (slv_rsp_w)
	);

	scratch_ram u_scratch_ram (
		.clk_2x_w (clk_2x_w),
		.req_i    (slv_req_w),
		.sel_i    (slv_sel_w[SLOT_RAM]),
		.rsp_o    (slv_rsp_w[SLOT_RAM])
	);

	dev_table u_dev_table (
		.clk_2x_w (clk_2x_w),
		.req_i    (slv_req_w),
		.sel_i    (slv_sel_w[SLOT_DEVTBL]),
		.rsp_o    (slv_rsp_w[SLOT_DEVTBL])
	);

	gpio_port u_gpio_port (
		.clk_2x_w  (clk_2x_w),
		.rst_p     (rst_p),
		.req_i     (slv_req_w),
		.sel_i     (slv_sel_w[SLOT_GPIO]),
		.rsp_o     (slv_rsp_w[SLOT_GPIO]),
		.gpio_i    (gpio_i),
		.gpio_o    (gpio_o),
		.intrqst_o (intrqst_w[INT_SRC_GPIO]),
		.intrdy_i  (intrdy_w[INT_SRC_GPIO])
	);

	int_ctrl u_int_ctrl (
		.clk_2x_w  (clk_2x_w),
		.rst_p     (rst_p),
		.req_i     (slv_req_w),
		.sel_i     (slv_sel_w[SLOT_INTCTRL]),
		.rsp_o     (slv_rsp_w[SLOT_INTCTRL]),
		.intrqst_i (intrqst_w),
		.intrdy_o  (intrdy_w),
		.irq_o     (irq_o)
	);

	dma_engine u_dma_engine (
		.clk_2x_w  (clk_2x_w),
		.rst_p     (rst_p),
		.req_i     (slv_req_w),
		.sel_i     (slv_sel_w[SLOT_DMA]),
		.rsp_o     (slv_rsp_w[SLOT_DMA]),
		.mst_req_o (dma_mst_req_w),
		.mst_rsp_i (dma_mst_rsp_w),
		.intrqst_o (intrqst_w[INT_SRC_DMA]),
		.intrdy_i  (intrdy_w[INT_SRC_DMA])
	);

endmodule

// File: testbench/soc_bus_properties.sv
// ####################
// APB protocol checks
// Bound into the bus fabric, watches the host
// and DMA requesters and the shared slave request
// ####################
module soc_bus_properties (
	input logic                               clk_2x_w,
	input logic                               rst_p,
	input soc_bus_pkg::apb_req_t              host_req_i,
	input soc_bus_pkg::apb_rsp_t              host_rsp_i,
	input soc_bus_pkg::apb_req_t              dma_req_i,
	input soc_bus_pkg::apb_req_t              slv_req_i,
	input logic [soc_map_pkg::SLOT_COUNT-1:0] slv_sel_i
);
	timeunit 1ns;
	timeprecision 1ps;

	int failures = 0;

	// Host keeps its request up until the fabric answers
	host_psel_hold: assert property (@(posedge clk_2x_w) disable iff (rst_p)
		host_req_i.psel && !host_rsp_i.pready |=> host_req_i.psel)
	else begin
		failures++;
		$error("host psel dropped before pready");
	end

	// The DMA requester moves from its setup cycle to access one cycle later
	enable_after_setup: assert property (@(posedge clk_2x_w) disable iff (rst_p)
		dma_req_i.psel && !dma_req_i.penable |=> dma_req_i.penable)
	else begin
		failures++;
		$error("DMA penable did not follow its setup cycle");
	end

	// At most one slave, and the same one from setup through access
	slot_select_held: assert property (@(posedge clk_2x_w) disable iff (rst_p)
		slv_req_i.psel && !slv_req_i.penable |=> $onehot0(slv_sel_i) && $stable(slv_sel_i))
	else begin
		failures++;
		$error("slave select not one-hot or changed between setup and access");
	end

endmodule

// File: testbench/tb_soc_top.sv
// ####################
// Testbench for the peripheral system
// Runs a trace of host bus transfers, GPIO
// stimulus and interrupt waits against the DUT
// ####################
module tb_soc_top;
	timeunit 1ns;
	timeprecision 1ps;

	import soc_bus_pkg::*;
	import soc_map_pkg::*;

	localparam int CLK_PERIOD   = 20;
	localparam int RESET_CYCLES = 10;
	localparam int XFER_TIMEOUT = 200;
	localparam int IRQ_TIMEOUT  = 2000;

	logic              clk_2x_w;
	logic              rst_p;
	apb_req_t          host_req;
	apb_rsp_t          host_rsp;
	logic [GPIO_W-1:0] gpio_in;
	logic [GPIO_W-1:0] gpio_out;
	logic              irq;
	int                mismatch_count;
	int                failure_count;

	soc_top u_soc_top (
		.clk_2x_w   (clk_2x_w),
		.rst_p      (rst_p),
		.host_req_i (host_req),
		.host_rsp_o (host_rsp),
		.gpio_i     (gpio_in),
		.gpio_o     (gpio_out),
		.irq_o      (irq)
	);

	bind bus_fabric soc_bus_properties u_soc_bus_properties (
		.clk_2x_w   (clk_2x_w),
		.rst_p      (rst_p),
		.host_req_i (host_req_i),
		.host_rsp_i (host_rsp_o),
		.dma_req_i  (dma_req_i),
		.slv_req_i  (slv_req_o),
		.slv_sel_i  (slv_sel_o)
	);

	initial begin
		clk_2x_w = 1'b0;
		forever begin
			#(CLK_PERIOD / 2) clk_2x_w = ~clk_2x_w;
		end
	end

	task automatic check_value(input string name, input logic [DATA_W-1:0] expected,
		input logic [DATA_W-1:0] actual);
		if (actual !== expected) begin
			$display("MISMATCH at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
			mismatch_count++;
		end
	endtask

	// One APB transfer from the host port, done is low on a timeout
	task automatic bus_transfer(input logic write, input logic [ADDR_W-1:0] addr,
		input logic [DATA_W-1:0] wdata, input logic [STRB_W-1:0] strb,
		output logic [DATA_W-1:0] rdata, output logic done);
		int wait_cycles;
		wait_cycles = 0;
		@(negedge clk_2x_w);
		host_req.psel    = 1'b1;
		host_req.penable = 1'b0;
		host_req.pwrite  = write;
		host_req.paddr   = addr;
		host_req.pwdata  = wdata;
		host_req.pstrb   = write ? strb : '0;
		@(negedge clk_2x_w);
		host_req.penable = 1'b1;
		// pready is looked at a quarter period after the falling edge
		#(CLK_PERIOD / 4);
		while (!host_rsp.pready && wait_cycles < XFER_TIMEOUT) begin
			@(negedge clk_2x_w);
			#(CLK_PERIOD / 4);
			wait_cycles++;
		end
		done  = host_rsp.pready;
		rdata = host_rsp.prdata;
		@(negedge clk_2x_w);
		host_req = '0;
	endtask

	task automatic wait_for_irq(input logic level, output logic done);
		int wait_cycles;
		wait_cycles = 0;
		@(negedge clk_2x_w);
		while (irq !== level && wait_cycles < IRQ_TIMEOUT) begin
			@(negedge clk_2x_w);
			wait_cycles++;
		end
		done = (irq === level);
	endtask

	task automatic run_trace_step(input logic [7:0] op, input logic [ADDR_W-1:0] addr,
		input logic [DATA_W-1:0] data, input logic [STRB_W-1:0] strb,
		input logic [DATA_W-1:0] expected, input int line_no);
		logic [DATA_W-1:0] rdata;
		logic              done;
		done = 1'b1;
		case (op)
			"W": bus_transfer(1'b1, addr, data, strb, rdata, done);
			"R": begin
				bus_transfer(1'b0, addr, '0, strb, rdata, done);
				if (done) begin
					check_value($sformatf("prdata[%h]", addr), expected, rdata);
				end
			end
			"G": begin
				@(negedge clk_2x_w);
				gpio_in = data[GPIO_W-1:0];
			end
			"I": wait_for_irq(expected[0], done);
			"Q": begin
				@(negedge clk_2x_w);
				check_value("gpio_o", expected, {{(DATA_W-GPIO_W){1'b0}}, gpio_out});
			end
			default: begin
				$display("ERROR: trace line %0d has an unknown op %c", line_no, op);
				failure_count++;
			end
		endcase
		if (!done) begin
			$display("ERROR: trace line %0d (op %c, addr %h) timed out", line_no, op, addr);
			failure_count++;
		end
	endtask

	initial begin
		int                fd;
		int                fields;
		int                line_no;
		int                assert_failures;
		string             line;
		logic [7:0]        op;
		logic [ADDR_W-1:0] addr;
		logic [DATA_W-1:0] data;
		logic [STRB_W-1:0] strb;
		logic [DATA_W-1:0] expected;

		mismatch_count = 0;
		failure_count  = 0;
		line_no        = 0;
		rst_p          = 1'b1;
		host_req       = '0;
		gpio_in        = '0;
		repeat (RESET_CYCLES) @(posedge clk_2x_w);
		@(negedge clk_2x_w);
		rst_p = 1'b0;

		fd = $fopen("testbench/soc_trace.txt", "r");
		if (fd == 0) begin
			$display("ERROR: cannot open the trace file testbench/soc_trace.txt");
			failure_count++;
		end else begin
			// A timeout or a bad line stops the trace
			while (failure_count == 0 && $fgets(line, fd) != 0) begin
				line_no++;
				if (line.len() > 1 && line.getc(0) != "#") begin
					fields = $sscanf(line, "%c %h %h %h %h", op, addr, data, strb, expected);
					if (fields != 5) begin
						$display("ERROR: trace line %0d does not have five fields", line_no);
						failure_count++;
					end else begin
						run_trace_step(op, addr, data, strb, expected, line_no);
					end
				end
			end
			$fclose(fd);
		end

		assert_failures = u_soc_top.u_bus_fabric.u_soc_bus_properties.failures;
		$display("Errors: %0d mismatches, %0d run failures, %0d assertion failures",
			mismatch_count, failure_count, assert_failures);
		if (mismatch_count == 0 && failure_count == 0 && assert_failures == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

// File: testbench/soc_trace.txt
# op addr data strb expected, all hex after the op letter
# W write, R read and compare, G drive gpio_i, I wait for irq_o level, Q check gpio_o
W 0000 12345678 f 00000000
R 0000 00000000 f 12345678
W 0000 aabbccdd 5 00000000
R 0000 00000000 f 12bb56dd
R 1000 00000000 f 00000001
R 1004 00000000 f 00001000
R 1008 00000000 f 00000000
R 1010 00000000 f 00000007
R 1014 00000000 f 00001000
R 1018 00000000 f 00000000
R 1020 00000000 f 00000006
R 1024 00000000 f 00001000
R 1028 00000000 f 00000001
R 1030 00000000 f 00000003
R 1034 00000000 f 00001000
R 1038 00000000 f 00000000
R 1040 00000000 f 00000002
R 1044 00000000 f 00001000
R 1048 00000000 f 00000001
R 8000 00000000 f 00000000
W 8000 deadbeef f 00000000
R 0000 00000000 f 12bb56dd
W 2004 0000a5c3 f 00000000
Q 0000 00000000 0 0000a5c3
W 3004 00000001 f 00000000
G 0000 00005a5a 0 00000000
I 0000 00000000 0 00000001
R 2000 00000000 f 00005a5a
R 3000 00000000 f 00000001
W 3000 00000001 f 00000000
I 0000 00000000 0 00000000
W 0100 11111111 f 00000000
W 0104 22222222 f 00000000
W 0108 33333333 f 00000000
W 010c 44444444 f 00000000
W 3004 00000003 f 00000000
W 4000 00000100 f 00000000
W 4004 00000200 f 00000000
W 4008 00000004 f 00000000
R 400c 00000000 f 00000001
W 0300 cafef00d f 00000000
R 0300 00000000 f cafef00d
R 0104 00000000 f 22222222
I 0000 00000000 0 00000001
R 400c 00000000 f 00000000
R 3000 00000000 f 00000002
R 0200 00000000 f 11111111
R 0204 00000000 f 22222222
R 0208 00000000 f 33333333
R 020c 00000000 f 44444444
R 0300 00000000 f cafef00d
W 3000 00000002 f 00000000
I 0000 00000000 0 00000000

// File: project.f
hdl/soc_bus_pkg.sv
hdl/soc_map_pkg.sv
hdl/scratch_ram.sv
hdl/dev_table.sv
hdl/gpio_port.sv
hdl/int_ctrl.sv
hdl/dma_engine.sv
hdl/bus_fabric.sv
hdl/soc_top.sv
testbench/soc_bus_properties.sv
testbench/tb_soc_top.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator, then look for the pass line in the log
verilator --binary --assert --top-module tb_soc_top -f project.f -o sim_soc && \
	./obj_dir/sim_soc 2>&1 | tee sim.log && \
	grep -q "^Simulation finished: PASS$" sim.log && \
	echo "run_sim: passed" || { echo "run_sim: failed"; exit 1; }
